/* compile.f */
verilog/periph_pkg.sv
verilog/periph_decoder.sv
verilog/gpio_regs.sv
verilog/pwm_regs.sv
verilog/pwm_channel.sv
verilog/periph_top.sv
bench/tb_clock.sv
bench/tb_periph.sv

/* Makefile */
# Verilator build and run of the peripheral cluster testbench.
VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exit code is ignored; the log decides.
run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_periph.sv */
// Peripheral cluster testbench with random bus traffic checked against a register model.
`timescale 1ns/100ps
`default_nettype none

module tb_periph
    import periph_pkg::*;
();
    localparam int num_chan      = 4;
    localparam int chan_bits     = $clog2(num_chan);
    localparam int reset_timeout = 100;
    localparam int num_accesses  = 2000;

    logic                clk;
    logic                rst;
    bus_req_t            req;
    bus_rsp_t            rsp;
    logic[31:0]          gpio_in;
    logic[31:0]          gpio_out;
    logic[31:0]          gpio_oe;

    // Register model.
    logic[31:0]          sh_out;
    logic[31:0]          sh_oe;
    logic[num_chan-1:0]  sh_sel;
    pwm_cfg_t            sh_cfg[num_chan];
    bus_rsp_t            pending;

    tb_clock clock_gen (
        .clk    (clk),
        .rst    (rst)
    );

    periph_top #(.num_pwm(num_chan)) dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .gpio_out   (gpio_out),
        .gpio_oe    (gpio_oe),
        .gpio_in    (gpio_in)
    );

    task automatic stop_on_error();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t want);
        if (got !== want) begin
            $display("** Error: rsp = %h, expected %h (valid %h err %h rdata %h)",
                     got, want, want.valid, want.err, want.rdata);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input logic[31:0] got, input logic[31:0] want);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_pwm_high(input int ch, input int got, input int want);
        if (got != want) begin
            $display("** Error: pwm_out[%0d] high count = %h, expected %h", ch, got, want);
            stop_on_error();
        end
    endtask

    // Response of one request from the register map, then its write side effect.
    task automatic model_step(input bus_req_t r, output bus_rsp_t e);
        logic[7:0]            off;
        logic[3:0]            sub;
        logic[chan_bits-1:0]  idx;
        logic                 bad;
        logic[31:0]           rd;
        off = r.addr[7:0];
        sub = r.addr[3:0];
        idx = r.addr[4+chan_bits-1:4];
        bad = 1'b0;
        rd  = 32'h0;
        e   = '0;
        if (r.valid) begin
            case (r.addr[11:8])
                4'h0: rd = (off == 8'h00) ? periph_id : 32'h0;
                4'h2: begin
                    case (off)
                        8'h00: rd = sh_out;
                        8'h04: rd = sh_oe;
                        8'h08: begin
                            rd  = gpio_in;
                            bad = r.write;
                        end
                        8'h0c: rd = 32'(sh_sel);
                        default: bad = 1'b1;
                    endcase
                end
                4'h4: begin
                    if (r.addr[7:4] >= 4'(num_chan) || !(sub inside {4'h0, 4'h4, 4'h8}))
                        bad = 1'b1;
                    else if (sub == 4'h0)
                        rd = {16'h0, sh_cfg[idx].period};
                    else if (sub == 4'h4)
                        rd = {16'h0, sh_cfg[idx].duty};
                    else
                        rd = {31'h0, sh_cfg[idx].enable};
                end
                default: bad = 1'b1;
            endcase
            e.valid = 1'b1;
            e.err   = bad;
            e.rdata = (r.write || bad) ? 32'h0 : rd;
            if (r.write && !bad && r.addr[11:8] == 4'h2) begin
                if (off == 8'h00) sh_out = r.wdata;
                if (off == 8'h04) sh_oe = r.wdata;
                if (off == 8'h0c) sh_sel = r.wdata[num_chan-1:0];
            end
            if (r.write && !bad && r.addr[11:8] == 4'h4) begin
                if (sub == 4'h0) sh_cfg[idx].period = r.wdata[15:0];
                if (sub == 4'h4) sh_cfg[idx].duty = r.wdata[15:0];
                if (sub == 4'h8) sh_cfg[idx].enable = r.wdata[0];
            end
        end
    endtask

    // Outputs are settled at the falling edge.
    always @(negedge clk) begin
        logic[31:0] mask;
        if (rst) begin
            check_rsp(rsp, '0);
            check_word("gpio_out", gpio_out, 32'h0);
            check_word("gpio_oe", gpio_oe, 32'h0);
            sh_out  = 32'h0;
            sh_oe   = 32'h0;
            sh_sel  = '0;
            sh_cfg  = '{default: '0};
            pending = '0;
        end else begin
            check_rsp(rsp, pending);
            mask = 32'(sh_sel);
            check_word("gpio_oe", gpio_oe, sh_oe | mask);
            check_word("gpio_out", gpio_out & ~mask, sh_out & ~mask);
            model_step(req, pending);
        end
    end

    task automatic issue(input bus_req_t r);
        @(posedge clk);
        req <= r;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req <= '0;
        end
    endtask

    task automatic write_reg(input logic[11:0] addr, input logic[31:0] data);
        bus_req_t r;
        r.valid = 1'b1;
        r.write = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        issue(r);
    endtask

    // Mix of ID, GPIO, PWM (channels 0 to 7) and arbitrary addresses.
    function automatic bus_req_t random_req();
        bus_req_t   r;
        logic[7:0]  off;
        off     = {6'($urandom % 64), 2'b00};
        r.valid = 1'b1;
        r.write = 1'($urandom % 2);
        r.wdata = $urandom;
        case ($urandom % 6)
            0: r.addr = {4'h0, ($urandom % 2 == 0) ? 8'h00 : off};
            1, 2: r.addr = {4'h2, ($urandom % 4 != 0) ? {4'h0, 2'($urandom % 4), 2'b00} : off};
            3, 4: r.addr = {4'h4, 1'b0, 3'($urandom % 8), 2'($urandom % 4), 2'b00};
            default: r.addr = 12'($urandom) & 12'hffc;
        endcase
        return r;
    endfunction

    // Program one channel and count its high cycles over one full period.
    task automatic measure_pwm(input int ch, input logic[15:0] period,
                               input logic[15:0] duty, input logic en);
        logic[11:0] base;
        int         high;
        int         window;
        int         want;
        base = 12'h400 + 12'(ch * 16);
        write_reg(base, {16'h0, period});
        write_reg(base + 12'h4, {16'h0, duty});
        write_reg(base + 12'h8, {31'h0, en});
        drive_idle(4);
        window = en ? int'(period) + 1 : 64;
        if (!en)
            want = 0;
        else if (int'(duty) < window)
            want = int'(duty);
        else
            want = window;
        high = 0;
        repeat (window) begin
            @(negedge clk);
            if (gpio_out[5'(ch)]) high++;
        end
        check_pwm_high(ch, high, want);
    endtask

    initial begin
        int          waited;
        logic[15:0]  period;
        logic[15:0]  duty;
        req       = '0;
        gpio_in   = 32'h0;
        void'($urandom(32'h6301_30f8));

        waited = 0;
        while (rst && waited < reset_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (rst) begin
            $display("Timeout: reset still asserted after %0d cycles", reset_timeout);
            stop_on_error();
        end

        for (int i = 0; i < num_accesses; i++) begin
            // New pin inputs, then quiet cycles through the synchronizer.
            if ($urandom % 32 == 0) begin
                @(posedge clk);
                req     <= '0;
                gpio_in <= $urandom;
                drive_idle(3);
            end
            issue(random_req());
            drive_idle(int'($urandom % 3));
        end

        // All low pins follow their PWM channel.
        drive_idle(1);
        write_reg(12'h20c, 32'(4'hf));
        for (int round = 0; round < 3; round++) begin
            for (int ch = 0; ch < num_chan; ch++) begin
                period = 16'($urandom % 40);
                duty   = 16'($urandom % (32'(period) + 32'd4));
                measure_pwm(ch, period, duty, round != 2);
            end
        end
        drive_idle(2);

        $display("RESULT: PASS");
        $finish;
    end
endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// Testbench clock and reset: 100 ns clock, reset held high for the first cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    // Rising edges with reset asserted.
    parameter int reset_cycles = 16
)(
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

`default_nettype wire

/* verilog/periph_top.sv */
// Peripheral cluster top: decoder, ID register, GPIO block and PWM generators.
`timescale 1ns/100ps
`default_nettype none

module periph_top
    import periph_pkg::*;
#(
    // Number of PWM channels, 1 to max_pwm.
    parameter integer num_pwm = 4
)(
    // Bus clock, also runs the PWM counters.
    input  logic        clk,
    // Synchronous reset.
    input  logic        rst,

    // Request from the bus master.
    input  bus_req_t    req,
    // Response, one cycle after the request.
    output bus_rsp_t    rsp,

    // Pin outputs.
    output logic[31:0]  gpio_out,
    // Pin output enables.
    output logic[31:0]  gpio_oe,
    // Pin inputs.
    input  logic[31:0]  gpio_in
);
    // Region buses.
    bus_req_t           gpio_req;
    bus_req_t           pwm_req;
    logic[31:0]         gpio_rdata;
    logic[31:0]         pwm_rdata;
    logic               gpio_err;
    logic               pwm_err;

    // PWM channel wiring.
    pwm_cfg_t           cfg[num_pwm];
    logic[num_pwm-1:0]  restart;
    logic[num_pwm-1:0]  pwm_out;

    periph_decoder decoder (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .gpio_req   (gpio_req),
        .gpio_rdata (gpio_rdata),
        .gpio_err   (gpio_err),
        .pwm_req    (pwm_req),
        .pwm_rdata  (pwm_rdata),
        .pwm_err    (pwm_err)
    );

    gpio_regs #(.num_pwm(num_pwm)) gpio (
        .clk        (clk),
        .rst        (rst),
        .req        (gpio_req),
        .rdata      (gpio_rdata),
        .err        (gpio_err),
        .pwm_out    (pwm_out),
        .gpio_out   (gpio_out),
        .gpio_oe    (gpio_oe),
        .gpio_in    (gpio_in)
    );

    pwm_regs #(.num_pwm(num_pwm)) pwm_cfg_regs (
        .clk        (clk),
        .rst        (rst),
        .req        (pwm_req),
        .rdata      (pwm_rdata),
        .err        (pwm_err),
        .cfg        (cfg),
        .restart    (restart)
    );

    // One generator per channel.
    for (genvar i = 0; i < num_pwm; i++) begin : pwm_gen
        pwm_channel chan (
            .clk        (clk),
            .rst        (rst),
            .cfg        (cfg[i]),
            .restart    (restart[i]),
            .pwm_out    (pwm_out[i])
        );
    end
endmodule

`default_nettype wire

/* verilog/pwm_channel.sv */
// PWM generator: wrapping 16-bit counter with a registered duty compare.
`timescale 1ns/100ps
`default_nettype none

module pwm_channel
    import periph_pkg::*;
(
    // Bus clock.
    input  logic        clk,
    // Synchronous reset.
    input  logic        rst,

    // Period, duty and enable.
    input  pwm_cfg_t    cfg,
    // Clears the counter.
    input  logic        restart,

    // Generated signal.
    output logic        pwm_out
);
    logic[15:0] cnt;

    // Counts 0..period, then wraps.
    // The >= catches a period lowered below the running count.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= 16'h0;
        end else if (!cfg.enable || restart) begin
            cnt <= 16'h0;
        end else if (cnt >= cfg.period) begin
            cnt <= 16'h0;
        end else begin
            cnt <= cnt + 16'h1;
        end
    end

    // Duty above period keeps the output high.
    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= cfg.enable && (cnt < cfg.duty);
        end
    end

    // Bounded count, once the period has stayed put for a cycle.
    a_cnt_in_period: assert property (
        @(posedge clk) disable iff (rst)
        (cfg.enable && !restart && $stable(cfg.period)) |-> (cnt <= cfg.period)
    );
endmodule

`default_nettype wire

/* verilog/pwm_regs.sv */
// PWM configuration registers: per-channel period, duty and enable, with readback.
`timescale 1ns/100ps
`default_nettype none

module pwm_regs
    import periph_pkg::*;
#(
    // Number of implemented channels.
    parameter integer num_pwm = 4
)(
    // Bus clock.
    input  logic                clk,
    // Synchronous reset.
    input  logic                rst,

    // Region request, offset only.
    input  bus_req_t            req,
    // Combinational read data.
    output logic[31:0]          rdata,
    // Missing channel or bad offset.
    output logic                err,

    // Settings of each channel.
    output pwm_cfg_t            cfg[num_pwm],
    // Counter restart, high while a ctrl write is in flight.
    output logic[num_pwm-1:0]   restart
);
    logic[7:0]  chan;
    logic[3:0]  off;
    logic       wr_en;
    pwm_cfg_t   cur;

    initial assert (num_pwm >= 1 && num_pwm <= max_pwm)
        else $fatal(1, "num_pwm out of range");

    // Channel index and register offset within the channel.
    assign chan  = 8'(req.addr[7:0] / pwm_stride);
    assign off   = 4'(req.addr[7:0] % pwm_stride);
    assign wr_en = req.valid && req.write && !err;

    // Settings of the addressed channel, zero if it does not exist.
    always_comb begin
        cur = '0;
        for (int i = 0; i < num_pwm; i++) begin
            if (chan == 8'(i)) cur = cfg[i];
        end
    end

    always_comb begin
        err   = (chan >= 8'(num_pwm));
        rdata = 32'h0;
        case (off)
            pwm_period_off: rdata = {16'h0, cur.period};
            pwm_duty_off:   rdata = {16'h0, cur.duty};
            pwm_ctrl_off:   rdata = {31'h0, cur.enable};
            default:        err   = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_pwm; i++) begin
            if (rst) begin
                cfg[i] <= '0;
            end else if (wr_en && chan == 8'(i)) begin
                case (off)
                    pwm_period_off: cfg[i].period <= req.wdata[15:0];
                    pwm_duty_off:   cfg[i].duty   <= req.wdata[15:0];
                    pwm_ctrl_off:   cfg[i].enable <= req.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // Counter is cleared on the same edge that takes the new ctrl value.
    always_comb begin
        for (int i = 0; i < num_pwm; i++) begin
            restart[i] = wr_en && (chan == 8'(i)) && (off == pwm_ctrl_off);
        end
    end
endmodule

`default_nettype wire

/* verilog/gpio_regs.sv */
// GPIO block: output, enable and PWM-select registers, input sync and pin muxing.
`timescale 1ns/100ps
`default_nettype none

module gpio_regs
    import periph_pkg::*;
#(
    // Number of PWM channels that can drive low pins.
    parameter integer num_pwm = 4
)(
    // Bus clock.
    input  logic                clk,
    // Synchronous reset.
    input  logic                rst,

    // Region request, offset only.
    input  bus_req_t            req,
    // Combinational read data.
    output logic[31:0]          rdata,
    // Bad offset, or write to the input register.
    output logic                err,

    // PWM signals for the low pins.
    input  logic[num_pwm-1:0]   pwm_out,

    // Pin outputs.
    output logic[31:0]          gpio_out,
    // Pin output enables.
    output logic[31:0]          gpio_oe,
    // Pin inputs, asynchronous.
    input  logic[31:0]          gpio_in
);
    logic[31:0]         out_q;
    logic[31:0]         oe_q;
    logic[num_pwm-1:0]  sel_q;
    logic[31:0]         sel_word;
    logic[31:0]         in_meta;
    logic[31:0]         in_sync;

    // Two-flop input synchronizer.
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= 32'h0;
            oe_q  <= 32'h0;
            sel_q <= '0;
        end else if (req.valid && req.write) begin
            case (req.addr[7:0])
                gpio_out_off: out_q <= req.wdata;
                gpio_oe_off:  oe_q  <= req.wdata;
                gpio_sel_off: sel_q <= req.wdata[num_pwm-1:0];
                default: ;
            endcase
        end
    end

    // Unused select bits read as zero.
    always_comb begin
        sel_word              = 32'h0;
        sel_word[num_pwm-1:0] = sel_q;
    end

    always_comb begin
        rdata = 32'h0;
        err   = 1'b0;
        case (req.addr[7:0])
            gpio_out_off: rdata = out_q;
            gpio_oe_off:  rdata = oe_q;
            gpio_in_off: begin
                rdata = in_sync;
                err   = req.write;
            end
            gpio_sel_off: rdata = sel_word;
            default:      err   = 1'b1;
        endcase
    end

    // Selected pins take the PWM signal and are always driven.
    always_comb begin
        gpio_out = out_q;
        gpio_oe  = oe_q;
        for (int i = 0; i < num_pwm; i++) begin
            if (sel_q[i]) begin
                gpio_out[i] = pwm_out[i];
                gpio_oe[i]  = 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

/* verilog/periph_decoder.sv */
// Peripheral decoder that splits requests by region, serves the ID word and registers the response.
`timescale 1ns/100ps
`default_nettype none

module periph_decoder
    import periph_pkg::*;
(
    // Bus clock.
    input  logic        clk,
    // Synchronous reset.
    input  logic        rst,

    // Request from the bus master.
    input  bus_req_t    req,
    // Response to the bus master.
    output bus_rsp_t    rsp,

    // GPIO region request and read data.
    output bus_req_t    gpio_req,
    input  logic[31:0]  gpio_rdata,
    input  logic        gpio_err,

    // PWM region request and read data.
    output bus_req_t    pwm_req,
    input  logic[31:0]  pwm_rdata,
    input  logic        pwm_err
);
    region_e    region;
    logic[31:0] sel_rdata;
    logic       sel_err;

    // Upper address nibble picks the region.
    always_comb begin
        case (req.addr[11:8])
            4'h0:    region = region_info;
            4'h2:    region = region_gpio;
            4'h4:    region = region_pwm;
            default: region = region_none;
        endcase
    end

    // Forward only the 8-bit offset, with valid gated per region.
    always_comb begin
        gpio_req       = req;
        gpio_req.valid = req.valid && (region == region_gpio);
        gpio_req.addr  = {4'h0, req.addr[7:0]};
        pwm_req        = req;
        pwm_req.valid  = req.valid && (region == region_pwm);
        pwm_req.addr   = {4'h0, req.addr[7:0]};
    end

    // Read data and error of the addressed region.
    // The info region never errors; writes to it are dropped.
    always_comb begin
        case (region)
            region_info: begin
                sel_rdata = (req.addr[7:0] == 8'h00) ? periph_id : 32'h0;
                sel_err   = 1'b0;
            end
            region_gpio: begin
                sel_rdata = gpio_rdata;
                sel_err   = gpio_err;
            end
            region_pwm: begin
                sel_rdata = pwm_rdata;
                sel_err   = pwm_err;
            end
            default: begin
                sel_rdata = 32'h0;
                sel_err   = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp.valid <= req.valid;
            rsp.err   <= req.valid && sel_err;
            rsp.rdata <= (req.valid && !req.write && !sel_err) ? sel_rdata : 32'h0;
        end
    end

    // An access outside the three regions is answered next cycle with err and no data.
    a_unmapped_err: assert property (
        @(posedge clk) disable iff (rst)
        (req.valid && !(req.addr[11:8] inside {4'h0, 4'h2, 4'h4}))
            |=> (rsp.valid && rsp.err && rsp.rdata == 32'h0)
    );
endmodule

`default_nettype wire

/* verilog/periph_pkg.sv */
// Peripheral cluster shared types: bus structs, PWM settings, region enum and register map.
`default_nettype none

package periph_pkg;
    // Single-word bus request, valid for one cycle.
    typedef struct packed {
        logic       valid;
        logic       write;
        logic[11:0] addr;
        logic[31:0] wdata;
    } bus_req_t;

    // Response, returned exactly one cycle after the request.
    typedef struct packed {
        logic       valid;
        logic       err;
        logic[31:0] rdata;
    } bus_rsp_t;

    // Address regions of the 12-bit peripheral space.
    typedef enum logic[1:0] {
        region_info,
        region_gpio,
        region_pwm,
        region_none
    } region_e;

    // Settings of one PWM channel.
    typedef struct packed {
        logic[15:0] period;
        logic[15:0] duty;
        logic       enable;
    } pwm_cfg_t;

    // GPIO register offsets within the region.
    localparam logic[7:0] gpio_out_off = 8'h00;
    localparam logic[7:0] gpio_oe_off  = 8'h04;
    localparam logic[7:0] gpio_in_off  = 8'h08;
    localparam logic[7:0] gpio_sel_off = 8'h0c;

    // PWM register offsets within one channel.
    localparam logic[3:0] pwm_period_off = 4'h0;
    localparam logic[3:0] pwm_duty_off   = 4'h4;
    localparam logic[3:0] pwm_ctrl_off   = 4'h8;
    localparam integer    pwm_stride     = 'h10;

    localparam logic[31:0] periph_id = 32'h7e1f_0001;
    localparam integer     max_pwm   = 8;
endpackage

`default_nettype wire
